/* design/rv_decode_pkg.sv */
// Shared widths, opcode and ALU encodings, and the structs passed between
// the RV32I decode blocks
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [5:0]      alu_code_t;
    typedef logic [1:0]      operand_sel_t;
    typedef logic [2:0]      insn_fmt_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    localparam alu_code_t ALU_NOP  = 6'd0;
    localparam alu_code_t ALU_ADD  = 6'd1;
    localparam alu_code_t ALU_SUB  = 6'd2;
    localparam alu_code_t ALU_SLL  = 6'd3;
    localparam alu_code_t ALU_SLT  = 6'd4;
    localparam alu_code_t ALU_SLTU = 6'd5;
    localparam alu_code_t ALU_XOR  = 6'd6;
    localparam alu_code_t ALU_SRL  = 6'd7;
    localparam alu_code_t ALU_SRA  = 6'd8;
    localparam alu_code_t ALU_OR   = 6'd9;
    localparam alu_code_t ALU_AND  = 6'd10;
    localparam alu_code_t ALU_LUI  = 6'd11;
    localparam alu_code_t ALU_JAL  = 6'd12;
    localparam alu_code_t ALU_JALR = 6'd13;
    localparam alu_code_t ALU_BEQ  = 6'd14;
    localparam alu_code_t ALU_BNE  = 6'd15;
    localparam alu_code_t ALU_BLT  = 6'd16;
    localparam alu_code_t ALU_BGE  = 6'd17;
    localparam alu_code_t ALU_BLTU = 6'd18;
    localparam alu_code_t ALU_BGEU = 6'd19;
    localparam alu_code_t ALU_LB   = 6'd20;
    localparam alu_code_t ALU_LH   = 6'd21;
    localparam alu_code_t ALU_LW   = 6'd22;
    localparam alu_code_t ALU_LBU  = 6'd23;
    localparam alu_code_t ALU_LHU  = 6'd24;
    localparam alu_code_t ALU_SB   = 6'd25;
    localparam alu_code_t ALU_SH   = 6'd26;
    localparam alu_code_t ALU_SW   = 6'd27;

    localparam operand_sel_t OPND_NONE = 2'd0;
    localparam operand_sel_t OPND_REG  = 2'd1;
    localparam operand_sel_t OPND_IMM  = 2'd2;
    localparam operand_sel_t OPND_PC   = 2'd3;

    localparam insn_fmt_t FMT_NONE = 3'd0;
    localparam insn_fmt_t FMT_R    = 3'd1;
    localparam insn_fmt_t FMT_I    = 3'd2;
    localparam insn_fmt_t FMT_S    = 3'd3;
    localparam insn_fmt_t FMT_B    = 3'd4;
    localparam insn_fmt_t FMT_U    = 3'd5;
    localparam insn_fmt_t FMT_J    = 3'd6;

    typedef struct packed {
        alu_code_t    alucode;
        operand_sel_t op1_sel;
        operand_sel_t op2_sel;
        insn_fmt_t    fmt;
        logic         rd_used;
        logic         link;     // JAL and JALR
        logic         is_load;
        logic         is_store;
    } ctrl_t;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_b;
        word_t    imm_u;
        word_t    imm_j;
    } fields_t;

    typedef struct packed {
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        reg_idx_t     rd;
        word_t        imm;
        alu_code_t    alucode;
        operand_sel_t op1_sel;
        operand_sel_t op2_sel;
        logic         reg_we;
        logic         is_load;
        logic         is_store;
    } decoded_t;

endpackage

`default_nettype wire

/* design/ctrl_decoder.sv */
// RV32I control decoder mapping opcode, funct3 and funct7 bit 5 to ALU code,
// operand selections, format and load/store flags
// Unknown encodings decode to all zeros
`timescale 1ns/1ns
`default_nettype none

module ctrl_decoder (
    input  rv_decode_pkg::word_t insn,
    output rv_decode_pkg::ctrl_t ctrl
);

    rv_decode_pkg::opcode_t   opcode;
    logic [2:0]               funct3;
    logic                     funct7_b5;
    rv_decode_pkg::alu_code_t arith_code;

    assign opcode    = insn[6:0];
    assign funct3    = insn[14:12];
    assign funct7_b5 = insn[30];

    function automatic rv_decode_pkg::ctrl_t make_ctrl(
        input rv_decode_pkg::alu_code_t    alucode,
        input rv_decode_pkg::operand_sel_t op1_sel,
        input rv_decode_pkg::operand_sel_t op2_sel,
        input rv_decode_pkg::insn_fmt_t    fmt
    );
        rv_decode_pkg::ctrl_t c;
        c         = '0;
        c.alucode = alucode;
        c.op1_sel = op1_sel;
        c.op2_sel = op2_sel;
        c.fmt     = fmt;
        c.rd_used = fmt inside {rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J,
                                rv_decode_pkg::FMT_I, rv_decode_pkg::FMT_R};
        return c;
    endfunction

    // OP and OP-IMM share one funct3 table
    always_comb begin
        case (funct3)
            3'b000: arith_code = (opcode == rv_decode_pkg::OPC_OP && funct7_b5) ?
                                 rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'b001: arith_code = rv_decode_pkg::ALU_SLL;
            3'b010: arith_code = rv_decode_pkg::ALU_SLT;
            3'b011: arith_code = rv_decode_pkg::ALU_SLTU;
            3'b100: arith_code = rv_decode_pkg::ALU_XOR;
            3'b101: arith_code = funct7_b5 ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'b110: arith_code = rv_decode_pkg::ALU_OR;
            default: arith_code = rv_decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv_decode_pkg::OPC_LUI:
                ctrl = make_ctrl(rv_decode_pkg::ALU_LUI, rv_decode_pkg::OPND_NONE,
                                 rv_decode_pkg::OPND_IMM, rv_decode_pkg::FMT_U);
            rv_decode_pkg::OPC_AUIPC:
                ctrl = make_ctrl(rv_decode_pkg::ALU_ADD, rv_decode_pkg::OPND_IMM,
                                 rv_decode_pkg::OPND_PC, rv_decode_pkg::FMT_U);
            rv_decode_pkg::OPC_JAL: begin
                ctrl = make_ctrl(rv_decode_pkg::ALU_JAL, rv_decode_pkg::OPND_NONE,
                                 rv_decode_pkg::OPND_PC, rv_decode_pkg::FMT_J);
                ctrl.link = 1'b1;
            end
            rv_decode_pkg::OPC_JALR: begin  // funct3 not checked
                ctrl = make_ctrl(rv_decode_pkg::ALU_JALR, rv_decode_pkg::OPND_REG,
                                 rv_decode_pkg::OPND_PC, rv_decode_pkg::FMT_I);
                ctrl.link = 1'b1;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: ctrl.alucode = rv_decode_pkg::ALU_BEQ;
                    3'b001: ctrl.alucode = rv_decode_pkg::ALU_BNE;
                    3'b100: ctrl.alucode = rv_decode_pkg::ALU_BLT;
                    3'b101: ctrl.alucode = rv_decode_pkg::ALU_BGE;
                    3'b110: ctrl.alucode = rv_decode_pkg::ALU_BLTU;
                    3'b111: ctrl.alucode = rv_decode_pkg::ALU_BGEU;
                    default: ctrl.alucode = rv_decode_pkg::ALU_NOP;
                endcase
                if (ctrl.alucode != rv_decode_pkg::ALU_NOP) begin
                    ctrl = make_ctrl(ctrl.alucode, rv_decode_pkg::OPND_REG,
                                     rv_decode_pkg::OPND_REG, rv_decode_pkg::FMT_B);
                end
            end
            rv_decode_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000: ctrl.alucode = rv_decode_pkg::ALU_LB;
                    3'b001: ctrl.alucode = rv_decode_pkg::ALU_LH;
                    3'b010: ctrl.alucode = rv_decode_pkg::ALU_LW;
                    3'b100: ctrl.alucode = rv_decode_pkg::ALU_LBU;
                    3'b101: ctrl.alucode = rv_decode_pkg::ALU_LHU;
                    default: ctrl.alucode = rv_decode_pkg::ALU_NOP;
                endcase
                if (ctrl.alucode != rv_decode_pkg::ALU_NOP) begin
                    ctrl = make_ctrl(ctrl.alucode, rv_decode_pkg::OPND_REG,
                                     rv_decode_pkg::OPND_IMM, rv_decode_pkg::FMT_I);
                    ctrl.is_load = 1'b1;
                end
            end
            rv_decode_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000: ctrl.alucode = rv_decode_pkg::ALU_SB;
                    3'b001: ctrl.alucode = rv_decode_pkg::ALU_SH;
                    3'b010: ctrl.alucode = rv_decode_pkg::ALU_SW;
                    default: ctrl.alucode = rv_decode_pkg::ALU_NOP;
                endcase
                if (ctrl.alucode != rv_decode_pkg::ALU_NOP) begin
                    ctrl = make_ctrl(ctrl.alucode, rv_decode_pkg::OPND_REG,
                                     rv_decode_pkg::OPND_IMM, rv_decode_pkg::FMT_S);
                    ctrl.is_store = 1'b1;
                end
            end
            rv_decode_pkg::OPC_OPIMM:
                ctrl = make_ctrl(arith_code, rv_decode_pkg::OPND_REG,
                                 rv_decode_pkg::OPND_IMM, rv_decode_pkg::FMT_I);
            rv_decode_pkg::OPC_OP:
                ctrl = make_ctrl(arith_code, rv_decode_pkg::OPND_REG,
                                 rv_decode_pkg::OPND_REG, rv_decode_pkg::FMT_R);
            default: ctrl = '0;  // Unknown opcode
        endcase
    end

    // Memory flags only for the listed load and store widths, never both
    mem_flag_legal: assert property (@(ctrl)
        !$isunknown(insn) |->
            (!ctrl.is_load || (opcode == rv_decode_pkg::OPC_LOAD &&
                               !(funct3 inside {3'b011, 3'b110, 3'b111}))) &&
            (!ctrl.is_store || (opcode == rv_decode_pkg::OPC_STORE && funct3 < 3'b011)));

endmodule

`default_nettype wire

/* design/operand_extractor.sv */
// Operand field extractor: register numbers and all five sign-extended
// immediate candidates, format-agnostic
`timescale 1ns/1ns
`default_nettype none

module operand_extractor (
    input  rv_decode_pkg::word_t   insn,
    output rv_decode_pkg::fields_t fields
);

    localparam int XLEN = rv_decode_pkg::XLEN;

    logic sign;

    assign sign = insn[31];

    assign fields.rs1 = insn[19:15];
    assign fields.rs2 = insn[24:20];
    assign fields.rd  = insn[11:7];

    assign fields.imm_i = {{(XLEN - 12){sign}}, insn[31:20]};

    assign fields.imm_s = {{(XLEN - 12){sign}}, insn[31:25], insn[11:7]};

    // Branch offset, halfword aligned
    assign fields.imm_b = {{(XLEN - 13){sign}}, insn[31], insn[7], insn[30:25],
                           insn[11:8], 1'b0};

    assign fields.imm_u = {insn[31:12], 12'd0};

    // Jump offset, halfword aligned
    assign fields.imm_j = {{(XLEN - 21){sign}}, insn[31], insn[19:12], insn[20],
                           insn[30:21], 1'b0};

endmodule

`default_nettype wire

/* design/decode_output_stage.sv */
// Output stage of the decoder: picks immediate and register numbers by format,
// registers the result on acceptance and tracks credits from the consumer
`timescale 1ns/1ns
`default_nettype none

module decode_output_stage #(
    parameter int unsigned CREDITS = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  rv_decode_pkg::ctrl_t    ctrl,
    input  rv_decode_pkg::fields_t  fields,
    input  logic                    credit_return,
    output logic                    out_valid,
    output rv_decode_pkg::decoded_t out
);

    localparam int CNT_W = (CREDITS > 0) ? $clog2(CREDITS + 1) : 1;

    rv_decode_pkg::decoded_t dec;
    logic                    accept;
    logic [CNT_W-1:0]        credit_cnt;

    always_comb begin
        dec          = '0;
        dec.alucode  = ctrl.alucode;
        dec.op1_sel  = ctrl.op1_sel;
        dec.op2_sel  = ctrl.op2_sel;
        dec.is_load  = ctrl.is_load;
        dec.is_store = ctrl.is_store;

        case (ctrl.fmt)
            rv_decode_pkg::FMT_I: dec.imm = fields.imm_i;
            rv_decode_pkg::FMT_S: dec.imm = fields.imm_s;
            rv_decode_pkg::FMT_B: dec.imm = fields.imm_b;
            rv_decode_pkg::FMT_U: dec.imm = fields.imm_u;
            rv_decode_pkg::FMT_J: dec.imm = fields.imm_j;
            default:              dec.imm = '0;  // R and NONE
        endcase

        if (!(ctrl.fmt inside {rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J,
                               rv_decode_pkg::FMT_NONE})) begin
            dec.rs1 = fields.rs1;
        end
        if (!(ctrl.fmt inside {rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J,
                               rv_decode_pkg::FMT_I, rv_decode_pkg::FMT_NONE})) begin
            dec.rs2 = fields.rs2;
        end
        if (ctrl.rd_used) begin
            dec.rd = fields.rd;
        end

        // Link to x0 is a plain jump
        dec.reg_we = ctrl.rd_used && !(ctrl.link && fields.rd == '0);
    end

    assign in_ready = (credit_cnt != '0);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= accept;  // One cycle per item
            if (accept) begin
                out <= dec;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else if (accept && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_return && !accept) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    credit_cnt_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= CNT_W'(CREDITS));

    // Consumer cannot free a slot that holds nothing
    no_excess_return: assert property (@(posedge clk) disable iff (!arst_n)
        credit_return |-> credit_cnt != CNT_W'(CREDITS));

endmodule

`default_nettype wire

/* design/insn_decoder_top.sv */
// RV32I decode stage with one cycle of latency and credit-based flow control
// toward a downstream issue buffer of CREDITS entries
`timescale 1ns/1ns
`default_nettype none

module insn_decoder_top #(
    parameter int unsigned CREDITS = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  rv_decode_pkg::word_t    insn,
    output logic                    out_valid,
    output rv_decode_pkg::decoded_t out,
    input  logic                    credit_return
);

    rv_decode_pkg::ctrl_t   ctrl;
    rv_decode_pkg::fields_t fields;

    ctrl_decoder ctrl_decoder_i (
        .insn (insn),
        .ctrl (ctrl)
    );

    operand_extractor operand_extractor_i (
        .insn   (insn),
        .fields (fields)
    );

    decode_output_stage #(
        .CREDITS (CREDITS)
    ) decode_output_stage_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .ctrl          (ctrl),
        .fields        (fields),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out           (out)
    );

endmodule

`default_nettype wire

/* verif/decode_model_pkg.sv */
// Testbench reference model: expected decode of one RV32I word, built from
// the ISA encoding rules and the shared ALU code numbering
`default_nettype none

package decode_model_pkg;

    // regs flags are rs1, rs2, rd
    function automatic rv_decode_pkg::decoded_t fill(
        input rv_decode_pkg::word_t     w,
        input rv_decode_pkg::alu_code_t alu,
        input rv_decode_pkg::word_t     imm,
        input logic [1:0]               op1,
        input logic [1:0]               op2,
        input logic [2:0]               regs
    );
        rv_decode_pkg::decoded_t d;
        d          = '0;
        d.alucode  = alu;
        d.imm      = imm;
        d.op1_sel  = op1;
        d.op2_sel  = op2;
        d.rs1      = regs[2] ? w[19:15] : 5'd0;
        d.rs2      = regs[1] ? w[24:20] : 5'd0;
        d.rd       = regs[0] ? w[11:7] : 5'd0;
        d.reg_we   = regs[0];
        d.is_load  = (w[6:0] == rv_decode_pkg::OPC_LOAD);
        d.is_store = (w[6:0] == rv_decode_pkg::OPC_STORE);
        return d;
    endfunction

    function automatic rv_decode_pkg::alu_code_t arith(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'b001: return rv_decode_pkg::ALU_SLL;
            3'b010: return rv_decode_pkg::ALU_SLT;
            3'b011: return rv_decode_pkg::ALU_SLTU;
            3'b100: return rv_decode_pkg::ALU_XOR;
            3'b101: return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'b110: return rv_decode_pkg::ALU_OR;
            default: return rv_decode_pkg::ALU_AND;
        endcase
    endfunction

    function automatic rv_decode_pkg::decoded_t decode_ref(input rv_decode_pkg::word_t w);
        rv_decode_pkg::decoded_t   d;
        rv_decode_pkg::alu_code_t  alu;
        rv_decode_pkg::word_t      i_imm;
        rv_decode_pkg::word_t      s_imm;
        rv_decode_pkg::word_t      b_imm;
        rv_decode_pkg::word_t      j_imm;
        logic [2:0]                f3;
        f3    = w[14:12];
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        d     = '0;
        case (w[6:0])
            rv_decode_pkg::OPC_LUI:
                d = fill(w, rv_decode_pkg::ALU_LUI, {w[31:12], 12'h000},
                         rv_decode_pkg::OPND_NONE, rv_decode_pkg::OPND_IMM, 3'b001);
            rv_decode_pkg::OPC_AUIPC:
                d = fill(w, rv_decode_pkg::ALU_ADD, {w[31:12], 12'h000},
                         rv_decode_pkg::OPND_IMM, rv_decode_pkg::OPND_PC, 3'b001);
            rv_decode_pkg::OPC_JAL:
                d = fill(w, rv_decode_pkg::ALU_JAL, j_imm,
                         rv_decode_pkg::OPND_NONE, rv_decode_pkg::OPND_PC, 3'b001);
            rv_decode_pkg::OPC_JALR:
                d = fill(w, rv_decode_pkg::ALU_JALR, i_imm,
                         rv_decode_pkg::OPND_REG, rv_decode_pkg::OPND_PC, 3'b101);
            rv_decode_pkg::OPC_BRANCH: begin
                alu = rv_decode_pkg::ALU_BEQ + ((f3 > 3'd3) ? f3 - 3'd2 : f3);
                if (!(f3 inside {3'b010, 3'b011})) begin
                    d = fill(w, alu, b_imm, rv_decode_pkg::OPND_REG,
                             rv_decode_pkg::OPND_REG, 3'b110);
                end
            end
            rv_decode_pkg::OPC_LOAD: begin
                alu = rv_decode_pkg::ALU_LB + ((f3 > 3'd3) ? f3 - 3'd1 : f3);
                if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    d = fill(w, alu, i_imm, rv_decode_pkg::OPND_REG,
                             rv_decode_pkg::OPND_IMM, 3'b101);
                end
            end
            rv_decode_pkg::OPC_STORE: begin
                alu = rv_decode_pkg::ALU_SB + f3;
                if (f3 < 3'd3) begin
                    d = fill(w, alu, s_imm, rv_decode_pkg::OPND_REG,
                             rv_decode_pkg::OPND_IMM, 3'b110);
                end
            end
            rv_decode_pkg::OPC_OPIMM:
                d = fill(w, arith(f3, w[30] && f3 == 3'b101), i_imm,
                         rv_decode_pkg::OPND_REG, rv_decode_pkg::OPND_IMM, 3'b101);
            rv_decode_pkg::OPC_OP:
                d = fill(w, arith(f3, w[30]), '0,
                         rv_decode_pkg::OPND_REG, rv_decode_pkg::OPND_REG, 3'b111);
            default: d = '0;
        endcase
        // A jump that links to x0 writes nothing
        if ((w[6:0] == rv_decode_pkg::OPC_JAL || w[6:0] == rv_decode_pkg::OPC_JALR) &&
            w[11:7] == 5'd0) begin
            d.reg_we = 1'b0;
        end
        return d;
    endfunction

endpackage

`default_nettype wire

/* verif/tb_insn_decoder.sv */
// Testbench for the RV32I decode stage: random and directed instructions,
// in-order scoreboard against the reference model, random credit return
`timescale 1ns/1ns
`default_nettype none

module tb_insn_decoder;

    localparam int CREDITS    = 4;
    localparam int WAIT_LIMIT = 1000;  // Cycles per wait loop

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    in_valid;
    logic                    in_ready;
    rv_decode_pkg::word_t    insn;
    logic                    out_valid;
    rv_decode_pkg::decoded_t out;
    logic                    credit_return;

    rv_decode_pkg::decoded_t exp_q[$];  // Expected results in order
    int errors       = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int err_base     = 0;
    int held         = 0;  // Items received and not yet returned
    int accepted     = 0;
    bit prev_accept  = 1'b0;
    bit auto_credit  = 1'b0;
    bit hung         = 1'b0;

    insn_decoder_top #(
        .CREDITS (CREDITS)
    ) insn_decoder_top_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .insn          (insn),
        .out_valid     (out_valid),
        .out           (out),
        .credit_return (credit_return)
    );

    always #2 clk = ~clk;

    task automatic report();
        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !hung) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout at %0t: %s", $time, reason);
        hung = 1'b1;
        report();
    endtask

    task automatic check_val(input string name, input logic [95:0] exp, input logic [95:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_decoded(input rv_decode_pkg::decoded_t e);
        check_val("out.rs1", e.rs1, out.rs1);
        check_val("out.rs2", e.rs2, out.rs2);
        check_val("out.rd", e.rd, out.rd);
        check_val("out.imm", e.imm, out.imm);
        check_val("out.alucode", e.alucode, out.alucode);
        check_val("out.op1_sel", e.op1_sel, out.op1_sel);
        check_val("out.op2_sel", e.op2_sel, out.op2_sel);
        check_val("out.reg_we", e.reg_we, out.reg_we);
        check_val("out.is_load", e.is_load, out.is_load);
        check_val("out.is_store", e.is_store, out.is_store);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_base) begin
            tests_failed++;
        end
        $display("Test %-18s done at %0t with %0d errors", name, $time, errors - err_base);
        err_base = errors;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send(input rv_decode_pkg::word_t w);
        int t;
        in_valid = 1'b1;
        insn     = w;
        t        = 0;
        @(negedge clk);
        while (!in_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!in_ready) begin
            abort_run("in_ready never rose for a waiting instruction");
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int t;
        auto_credit = 1'b1;
        t = 0;
        while ((exp_q.size() != 0 || held != 0) && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0 || held != 0) begin
            abort_run("outstanding items or credits did not drain");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_directed(input rv_decode_pkg::word_t w, input rv_decode_pkg::word_t imm,
                                 input logic we);
        int t;
        send(w);
        t = 0;
        @(negedge clk);
        while (!out_valid && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!out_valid) begin
            abort_run("directed instruction produced no output");
        end
        check_val("out.imm", imm, out.imm);
        check_val("out.reg_we", we, out.reg_we);
        @(posedge clk);
        #1;
    endtask

    function automatic rv_decode_pkg::word_t gen_legal();
        rv_decode_pkg::word_t w;
        w = $urandom();
        case ($urandom_range(0, 8))
            0: w[6:0] = rv_decode_pkg::OPC_LUI;
            1: w[6:0] = rv_decode_pkg::OPC_AUIPC;
            2: w[6:0] = rv_decode_pkg::OPC_JAL;
            3: begin
                w[6:0]   = rv_decode_pkg::OPC_JALR;
                w[14:12] = 3'b000;
            end
            4: begin
                w[6:0]   = rv_decode_pkg::OPC_BRANCH;
                w[14:12] = 3'($urandom_range(0, 5));
                if (w[14:12] > 3'd1)
                    w[14:12] = w[14:12] + 3'd2;  // Skip 010 and 011
            end
            5: begin
                w[6:0]   = rv_decode_pkg::OPC_LOAD;
                w[14:12] = 3'($urandom_range(0, 4));
                if (w[14:12] > 3'd2)
                    w[14:12] = w[14:12] + 3'd1;  // Skip 011
            end
            6: begin
                w[6:0]   = rv_decode_pkg::OPC_STORE;
                w[14:12] = 3'($urandom_range(0, 2));
            end
            7: begin
                w[6:0]   = rv_decode_pkg::OPC_OPIMM;
                w[31:25] = (w[14:12] == 3'b001) ? 7'd0 :
                           (w[14:12] == 3'b101) ? {1'b0, w[30], 5'd0} : w[31:25];
            end
            default: begin
                w[6:0]   = rv_decode_pkg::OPC_OP;
                w[31:25] = (w[14:12] inside {3'b000, 3'b101}) ? {1'b0, w[30], 5'd0} : 7'd0;
            end
        endcase
        return w;
    endfunction

    function automatic rv_decode_pkg::word_t gen_illegal();
        rv_decode_pkg::word_t w;
        w = $urandom();
        case ($urandom_range(0, 3))
            0: begin
                while (w[6:0] inside {rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC,
                                      rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR,
                                      rv_decode_pkg::OPC_BRANCH, rv_decode_pkg::OPC_LOAD,
                                      rv_decode_pkg::OPC_STORE, rv_decode_pkg::OPC_OPIMM,
                                      rv_decode_pkg::OPC_OP}) begin
                    w[6:0] = 7'($urandom());
                end
            end
            1: begin
                w[6:0]   = rv_decode_pkg::OPC_BRANCH;
                w[14:12] = 3'($urandom_range(2, 3));
            end
            2: begin
                w[6:0]   = rv_decode_pkg::OPC_LOAD;
                w[14:12] = 3'($urandom_range(5, 7));
                if (w[14:12] == 3'd5)
                    w[14:12] = 3'd3;
            end
            default: begin
                w[6:0]   = rv_decode_pkg::OPC_STORE;
                w[14:12] = 3'($urandom_range(3, 7));
            end
        endcase
        return w;
    endfunction

    // Consumer frees a slot after a random delay
    always @(posedge clk) begin
        #1;
        if (auto_credit) begin
            credit_return = (held > 0) && ($urandom_range(0, 2) == 0);
        end
    end

    // Scoreboard and latency check, sampled mid-cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            prev_accept = 1'b0;
        end else begin
            check_val("out_valid", prev_accept, out_valid);
            if (out_valid) begin
                held++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR t=%0t output appeared with no instruction outstanding", $time);
                end else begin
                    check_decoded(exp_q.pop_front());
                end
            end
            if (credit_return) begin
                held--;
            end
            prev_accept = in_valid && in_ready;
            if (prev_accept) begin
                accepted++;
                exp_q.push_back(decode_model_pkg::decode_ref(insn));
            end
        end
    end

    initial begin
        int base;
        void'($urandom(70286));
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        insn          = '0;
        credit_return = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_val("out_valid", 1'b0, out_valid);
        check_val("in_ready", 1'b1, in_ready);
        check_val("out", '0, out);
        repeat (CREDITS) begin
            check_val("in_ready", 1'b1, in_ready);
            send(gen_legal());
        end
        check_val("in_ready", 1'b0, in_ready);
        drain();
        end_test("reset");

        repeat (2000) begin
            send(gen_legal());
            if ($urandom_range(0, 7) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        drain();
        end_test("legal_decode");

        repeat (300) send(gen_illegal());
        repeat (200) send($urandom());
        drain();
        end_test("illegal_encodings");

        send_directed(32'hFFF0_0013, 32'hFFFF_FFFF, 1'b1);  // ADDI x0, x0, -1
        send_directed(32'h8000_006F, 32'hFFF0_0000, 1'b0);  // JAL x0
        send_directed(32'h8000_00EF, 32'hFFF0_0000, 1'b1);  // JAL x1
        send_directed(32'h0000_8067, 32'h0000_0000, 1'b0);  // JALR x0, 0(x1)
        send_directed(32'hFFFF_F2B7, 32'hFFFF_F000, 1'b1);  // LUI x5
        send_directed(32'hFE00_2FA3, 32'hFFFF_FFFF, 1'b0);  // SW, offset -1
        send_directed(32'h8000_00E3, 32'hFFFF_F800, 1'b0);  // BEQ, negative offset
        send_directed(32'h0020_8033, 32'h0000_0000, 1'b1);  // ADD x0, x1, x2
        drain();
        end_test("operand_rules");

        auto_credit   = 1'b0;
        credit_return = 1'b0;
        base          = accepted;
        repeat (CREDITS) begin
            check_val("in_ready", 1'b1, in_ready);
            send(gen_legal());
        end
        check_val("in_ready", 1'b0, in_ready);
        in_valid = 1'b1;
        insn     = gen_legal();
        repeat (6) begin
            @(negedge clk);
            check_val("in_ready", 1'b0, in_ready);
        end
        check_val("accepted", base + CREDITS, accepted);
        @(posedge clk);
        #1;
        credit_return = 1'b1;
        @(posedge clk);
        #1;
        credit_return = 1'b0;
        repeat (4) @(negedge clk);
        check_val("accepted", base + CREDITS + 1, accepted);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        drain();
        end_test("back_pressure");

        repeat (300) begin
            send(($urandom_range(0, 3) == 0) ? gen_illegal() : gen_legal());
        end
        drain();
        end_test("latency");

        report();
    end

endmodule

`default_nettype wire

/* verilog.f */
design/rv_decode_pkg.sv
design/ctrl_decoder.sv
design/operand_extractor.sv
design/decode_output_stage.sv
design/insn_decoder_top.sv
verif/decode_model_pkg.sv
verif/tb_insn_decoder.sv

/* Bender.yml */
package:
  name: insn_decoder

sources:
  - design/rv_decode_pkg.sv
  - design/ctrl_decoder.sv
  - design/operand_extractor.sv
  - design/decode_output_stage.sv
  - design/insn_decoder_top.sv
  - target: test
    files:
      - verif/decode_model_pkg.sv
      - verif/tb_insn_decoder.sv
